/* tb.f */
+incdir+include
logic/sys_pkg.sv
logic/sys_intf.sv
logic/sys_decode.sv
logic/perf_counters.sv
logic/sys_execute.sv
logic/sys_writeback.sv
logic/sys_unit_top.sv
tests/sys_unit_properties.sv
tests/sys_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the system-unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f tb.f \
    --top-module sys_unit_tb \
    -o sys_unit_sim

./obj_dir/sys_unit_sim

/* tests/sys_unit_tb.sv */
`timescale 1ns/10ps

`include "sys_settings.svh"

module sys_unit_tb
    import sys_pkg::*;
();

    typedef struct packed {
        logic [31:0]                word;
        retired_count_t             retired;    // Pulsed once before the instruction
        logic                       stall;      // Random wb_ready stalls
        logic [`REG_ADDR_WIDTH-1:0] exp_rd;
        logic                       exp_result;
    } stim_row_t;

    typedef struct packed {
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`XLEN-1:0]           value;
        logic                       is_cycle;   // Checked for growth only
        logic                       timed;      // Latency must be exactly 3
        logic [31:0]                accept;
    } expect_t;

    logic                       clk = 1'b0;
    logic                       rst;
    logic                       instr_valid;
    logic                       instr_ready;
    logic [31:0]                instr;
    retired_count_t             retired;
    logic                       wb_valid;
    logic                       wb_ready = 1'b1;
    logic [`REG_ADDR_WIDTH-1:0] wb_rd;
    logic [`XLEN-1:0]           wb_value;

    stim_row_t        stim_rows[$];
    expect_t          expected[$];  // Owed results with the oldest first
    expect_t          head;
    logic [63:0]      instret_sum;
    logic [`XLEN-1:0] last_cycle;
    logic [31:0]      cycles = '0;
    logic [31:0]      cycle_limit;
    logic             stall_mode;
    logic             next_ready;
    integer           rand_word;
    integer           seed = 38069;

    sys_unit_top sys_unit_top_inst (
        .clk,
        .rst,
        .instr_valid,
        .instr_ready,
        .instr,
        .retired,
        .wb_valid,
        .wb_ready,
        .wb_rd,
        .wb_value
    );

    always #20 clk = ~clk;

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_rd(input logic [`REG_ADDR_WIDTH-1:0] got,
                            input logic [`REG_ADDR_WIDTH-1:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("ERROR wb_rd: got 0x%h, expected 0x%h", got, exp));
        end
    endtask

    task automatic check_value(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("ERROR wb_value: got 0x%h, expected 0x%h", got, exp));
        end
    endtask

    // I-type SYSTEM word with rs1 = x0
    function automatic logic [31:0] csr_instr(input logic [11:0] csr, input sys_funct3_t op,
                                              input logic [4:0] rd);
        return {csr, 5'd0, op, rd, OP_SYSTEM};
    endfunction

    task automatic add_row(input logic [31:0] word, input retired_count_t ret,
                           input logic stall, input logic [4:0] rd, input logic res);
        stim_rows.push_back(stim_row_t'{word, ret, stall, rd, res});
    endtask

    task automatic build_table();
        add_row(csr_instr(CSR_INSTRET, CSRRS, 5'd5), 2'd3, 1'b0, 5'd5, 1'b1);
        add_row(csr_instr(CSR_INSTRET, CSRRS, 5'd6), 2'd2, 1'b0, 5'd6, 1'b1);
        add_row(csr_instr(CSR_INSTRETH, CSRRS, 5'd7), 2'd1, 1'b0, 5'd7, 1'b1);
        add_row(csr_instr(CSR_CYCLE, CSRRS, 5'd1), 2'd0, 1'b0, 5'd1, 1'b1);
        add_row(csr_instr(CSR_CYCLE, CSRRS, 5'd2), 2'd0, 1'b0, 5'd2, 1'b1);
        add_row(csr_instr(CSR_TIME, CSRRSI, 5'd3), 2'd0, 1'b0, 5'd3, 1'b1);
        add_row(csr_instr(CSR_CYCLEH, CSRRC, 5'd4), 2'd0, 1'b0, 5'd4, 1'b1);
        add_row(csr_instr(CSR_CYCLE, CSRRS, 5'd0), 2'd0, 1'b0, 5'd0, 1'b0); // x0 target
        add_row(32'h00000073, 2'd0, 1'b0, 5'd0, 1'b0);                      // ECALL
        add_row(32'h00100073, 2'd0, 1'b0, 5'd0, 1'b0);                      // EBREAK
        add_row(32'h00500293, 2'd0, 1'b0, 5'd0, 1'b0);                      // ADDI x5
        add_row(csr_instr(CSR_CYCLE, CSRRW, 5'd8), 2'd0, 1'b0, 5'd8, 1'b1);
        add_row(csr_instr(12'h300, CSRRS, 5'd9), 2'd0, 1'b0, 5'd9, 1'b1);    // Unknown CSR
        add_row(csr_instr(12'hC03, CSRRCI, 5'd10), 2'd0, 1'b0, 5'd10, 1'b1);
        add_row(csr_instr(CSR_TIMEH, CSRRWI, 5'd11), 2'd0, 1'b0, 5'd11, 1'b1);
        // From here on the write port stalls at random
        add_row(csr_instr(CSR_CYCLE, CSRRS, 5'd12), 2'd0, 1'b1, 5'd12, 1'b1);
        add_row(csr_instr(CSR_INSTRET, CSRRS, 5'd13), 2'd0, 1'b1, 5'd13, 1'b1);
        add_row(32'h00000073, 2'd0, 1'b1, 5'd0, 1'b0);
        add_row(csr_instr(CSR_TIME, CSRRS, 5'd14), 2'd0, 1'b1, 5'd14, 1'b1);
        add_row(32'h0000a303, 2'd0, 1'b1, 5'd0, 1'b0);                      // LW x6
        add_row(csr_instr(12'h7C0, CSRRC, 5'd15), 2'd0, 1'b1, 5'd15, 1'b1);
        add_row(csr_instr(CSR_CYCLE, CSRRS, 5'd16), 2'd0, 1'b1, 5'd16, 1'b1);
        add_row(csr_instr(CSR_INSTRETH, CSRRSI, 5'd17), 2'd0, 1'b1, 5'd17, 1'b1);
        add_row(csr_instr(CSR_TIME, CSRRS, 5'd18), 2'd0, 1'b1, 5'd18, 1'b1);
        add_row(csr_instr(CSR_INSTRET, CSRRW, 5'd31), 2'd0, 1'b1, 5'd31, 1'b1);
        add_row(csr_instr(CSR_CYCLEH, CSRRS, 5'd19), 2'd0, 1'b1, 5'd19, 1'b1);
    endtask

    // Reference CSR read from the counter rules
    task automatic model_result(input logic [31:0] word, output logic [`XLEN-1:0] value,
                                output logic is_cycle);
        value = '0;
        is_cycle = 1'b0;
        if (`ENABLE_PERF_COUNTERS != 0) begin
            case (word[31:20])
                CSR_CYCLE, CSR_TIME: is_cycle = 1'b1;  // Same counter behind both
                CSR_INSTRET:         value = instret_sum[31:0];
                CSR_INSTRETH:        value = instret_sum[63:32];
                default:             value = '0;       // Upper cycle half is still zero
            endcase
        end
    endtask

    task automatic apply_retired(input retired_count_t ret);
        retired = ret;
        instret_sum = instret_sum + 64'(ret);
        @(posedge clk);
        #2;
        retired = '0;
        repeat (4) @(posedge clk); // Carry reaches the upper half
        #2;
    endtask

    task automatic wait_for_drain();
        while (expected.size() != 0) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic send_instr(input stim_row_t row);
        logic [`XLEN-1:0] value;
        logic             is_cycle;
        instr_valid = 1'b1;
        instr = row.word;
        @(negedge clk);
        while (!instr_ready) begin
            @(posedge clk);
            #2;
            @(negedge clk);
        end
        if (row.exp_result) begin
            model_result(row.word, value, is_cycle);
            expected.push_back(expect_t'{row.exp_rd, value, is_cycle, !stall_mode, cycles});
        end
        @(posedge clk); // Accepting edge
        #2;
        instr_valid = 1'b0;
    endtask

    // Stall pattern picked at the edge and applied after the drive delay
    always @(posedge clk) begin
        rand_word = $random(seed);
        next_ready = stall_mode ? rand_word[0] : 1'b1;
        #2;
        wb_ready = next_ready;
    end

    always @(posedge clk) begin
        cycles <= cycles + 32'd1;
        if (cycles > cycle_limit) begin
            stop_with_failure($sformatf("Timeout after %0d cycles with %0d results outstanding",
                                        cycles, expected.size()));
        end
    end

    // A transfer happens on the coming edge
    always @(negedge clk) begin
        if (!rst && wb_valid && wb_ready) begin
            if (expected.size() == 0) begin
                stop_with_failure("Writeback seen while no result was outstanding");
            end else begin
                head = expected.pop_front();
                check_rd(wb_rd, head.rd);
                if (head.is_cycle) begin
                    if (wb_value <= last_cycle) begin
                        stop_with_failure($sformatf(
                            "ERROR wb_value: cycle read 0x%h is not above previous 0x%h",
                            wb_value, last_cycle));
                    end
                    last_cycle = wb_value;
                end else begin
                    check_value(wb_value, head.value);
                end
                if (head.timed && cycles != head.accept + 32'd3) begin
                    stop_with_failure($sformatf(
                        "Result for x%0d came %0d cycles after its instruction, not 3",
                        head.rd, cycles - head.accept));
                end
            end
        end
    end

    initial begin
        rst = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        retired = '0;
        stall_mode = 1'b0;
        instret_sum = '0;
        last_cycle = '0;
        build_table();
        cycle_limit = 32'(stim_rows.size() * 20);
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        foreach (stim_rows[i]) begin
            if (stim_rows[i].stall != stall_mode || stim_rows[i].retired != '0) begin
                wait_for_drain();
            end
            stall_mode = stim_rows[i].stall;
            if (stim_rows[i].retired != '0) begin
                apply_retired(stim_rows[i].retired);
            end
            send_instr(stim_rows[i]);
        end
        wait_for_drain();
        repeat (8) @(posedge clk); // Room for a stray extra writeback
        $display("Done: no errors");
        $finish;
    end

endmodule

/* tests/sys_unit_properties.sv */
`timescale 1ns/10ps

`include "sys_settings.svh"

module sys_unit_properties (
    input logic                       clk,
    input logic                       rst,
    input logic                       instr_ready,
    input logic                       cmd_valid,   // Decode entry full
    input logic                       res_valid,   // Execute entry full
    input logic                       wb_valid,
    input logic                       wb_ready,
    input logic [`REG_ADDR_WIDTH-1:0] wb_rd,
    input logic [`XLEN-1:0]           wb_value,
    input logic [`CNT_WIDTH-1:0]      cycle_count
);

    wb_low_after_reset: assert property (@(posedge clk) $past(rst) |-> !wb_valid)
        else $error("wb_valid high right after reset");

    wb_payload_held: assert property (@(posedge clk) disable iff (rst)
        (wb_valid && !wb_ready) |=> (wb_valid && $stable(wb_rd) && $stable(wb_value)))
        else $error("wb payload changed while stalled");

    // Nothing moves when every entry is full and the port stalls
    full_blocks_input: assert property (@(posedge clk) disable iff (rst)
        (cmd_valid && res_valid && wb_valid && !wb_ready) |-> !instr_ready)
        else $error("instr_ready high with all stages full");

    cycle_monotonic: assert property (@(posedge clk) disable iff (rst)
        cycle_count >= $past(cycle_count))
        else $error("cycle counter went backwards");

endmodule

bind sys_unit_top sys_unit_properties sys_unit_properties_inst (
    .clk,
    .rst,
    .instr_ready,
    .cmd_valid   (cmd_link.valid),
    .res_valid   (res_link.valid),
    .wb_valid,
    .wb_ready,
    .wb_rd,
    .wb_value,
    .cycle_count (sys_execute_inst.cycle_count)
);

/* logic/sys_unit_top.sv */
`timescale 1ns/10ps

`include "sys_settings.svh"

module sys_unit_top
    import sys_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       instr_valid,
    output logic                       instr_ready,
    input  logic [31:0]                instr,

    input  retired_count_t             retired, // From the core's retire logic

    output logic                       wb_valid,
    input  logic                       wb_ready,
    output logic [`REG_ADDR_WIDTH-1:0] wb_rd,
    output logic [`XLEN-1:0]           wb_value
);

    sys_cmd_intf    cmd_link ();
    sys_result_intf res_link ();

    sys_decode sys_decode_inst (
        .clk,
        .rst,
        .instr_valid,
        .instr_ready,
        .instr,
        .cmd_out (cmd_link.src)
    );

    // Owns the counters
    sys_execute sys_execute_inst (
        .clk,
        .rst,
        .retired,
        .cmd_in  (cmd_link.dst),
        .res_out (res_link.src)
    );

    sys_writeback sys_writeback_inst (
        .clk,
        .rst,
        .res_in  (res_link.dst),
        .wb_valid,
        .wb_ready,
        .wb_rd,
        .wb_value
    );

endmodule

/* logic/sys_writeback.sv */
`timescale 1ns/10ps

`include "sys_settings.svh"

module sys_writeback
    import sys_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,

    sys_result_intf.dst                res_in,

    output logic                       wb_valid,
    input  logic                       wb_ready,
    output logic [`REG_ADDR_WIDTH-1:0] wb_rd,
    output logic [`XLEN-1:0]           wb_value
);

    sys_result_t held;
    logic        take;

    // Accept when empty or when the register file takes the held result
    assign res_in.ready = !wb_valid || wb_ready;
    assign take = res_in.valid && res_in.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else if (res_in.ready) begin
            wb_valid <= res_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            held.rd <= res_in.rd;
            held.value <= res_in.value;
        end
    end

    assign wb_rd = held.rd;
    assign wb_value = held.value;

endmodule

/* logic/sys_execute.sv */
`timescale 1ns/10ps

`include "sys_settings.svh"

module sys_execute
    import sys_pkg::*;
(
    input  logic           clk,
    input  logic           rst,

    input  retired_count_t retired,

    sys_cmd_intf.dst       cmd_in,
    sys_result_intf.src    res_out
);

    logic [`CNT_WIDTH-1:0] cycle_count;
    logic [`CNT_WIDTH-1:0] instret_count;

    sys_cmd_t    cmd;
    sys_result_t next_result;
    logic        csr_form;
    logic        produce;
    logic        consume;

    perf_counters perf_counters_inst (
        .clk,
        .rst,
        .retired,
        .cycle_count,
        .instret_count
    );

    assign cmd = cmd_in.cmd;

    assign cmd_in.ready = !res_out.valid || res_out.ready;
    assign consume = cmd_in.valid && cmd_in.ready;

    // CSR read mux, old value only
    always_comb begin
        next_result.rd = cmd.rd;
        next_result.value = '0;
        if (`ENABLE_PERF_COUNTERS != 0) begin
            case (cmd.csr)
                CSR_CYCLE:    next_result.value = cycle_count[`XLEN-1:0];
                CSR_TIME:     next_result.value = cycle_count[`XLEN-1:0]; // Time tracks cycles
                CSR_INSTRET:  next_result.value = instret_count[`XLEN-1:0];
                CSR_CYCLEH:   next_result.value = cycle_count[`CNT_WIDTH-1:`XLEN];
                CSR_TIMEH:    next_result.value = cycle_count[`CNT_WIDTH-1:`XLEN];
                CSR_INSTRETH: next_result.value = instret_count[`CNT_WIDTH-1:`XLEN];
                default:      next_result.value = '0; // Unknown CSR
            endcase
        end
    end

    // Only CSR forms with a real destination write back
    always_comb begin
        case (cmd.sys_op)
            CSRRW, CSRRS, CSRRC: csr_form = 1'b1;
            CSRRWI, CSRRSI, CSRRCI: csr_form = 1'b1;
            default: csr_form = 1'b0; // ENV and reserved funct3
        endcase
        produce = cmd.is_system && csr_form && (cmd.rd != '0);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_out.valid <= 1'b0;
        end else if (cmd_in.ready) begin
            res_out.valid <= consume && produce; // Silent commands leave it empty
        end
    end

    always_ff @(posedge clk) begin
        if (consume && produce) begin
            res_out.rd <= next_result.rd;
            res_out.value <= next_result.value;
        end
    end

endmodule

/* logic/perf_counters.sv */
`timescale 1ns/10ps

`include "sys_settings.svh"

module perf_counters
    import sys_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    input  retired_count_t        retired,

    output logic [`CNT_WIDTH-1:0] cycle_count,
    output logic [`CNT_WIDTH-1:0] instret_count
);

    logic [`XLEN-1:0] cycle_lo;
    logic [`XLEN-1:0] cycle_hi;
    logic             cycle_carry;

    logic [`XLEN-1:0] instret_lo;
    logic [`XLEN-1:0] instret_hi;
    logic             instret_carry;

    // Each half is its own 32-bit adder; the carry crosses a register
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_lo <= '0;
            cycle_hi <= '0;
            cycle_carry <= 1'b0;
            instret_lo <= '0;
            instret_hi <= '0;
            instret_carry <= 1'b0;
        end else begin
            {cycle_carry, cycle_lo} <= {1'b0, cycle_lo} + {{`XLEN{1'b0}}, 1'b1};
            {instret_carry, instret_lo} <= {1'b0, instret_lo}
                + {{(`XLEN + 1 - `RETIRE_WIDTH){1'b0}}, retired};

            // Upper halves take last cycle's carry
            cycle_hi <= cycle_hi + {{(`XLEN - 1){1'b0}}, cycle_carry};
            instret_hi <= instret_hi + {{(`XLEN - 1){1'b0}}, instret_carry};
        end
    end

    // Lower half is one cycle fresher than the upper half
    assign cycle_count = {cycle_hi, cycle_lo};
    assign instret_count = {instret_hi, instret_lo};

endmodule

/* logic/sys_decode.sv */
`timescale 1ns/10ps

module sys_decode
    import sys_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        instr_valid,
    output logic        instr_ready,
    input  logic [31:0] instr,

    sys_cmd_intf.src    cmd_out
);

    opcode_t  opcode;
    sys_cmd_t next_cmd;
    logic     accept;

    // Entry free, or the held command leaves this cycle
    assign instr_ready = !cmd_out.valid || cmd_out.ready;
    assign accept = instr_valid && instr_ready;

    always_comb begin
        opcode = opcode_t'(instr[6:0]);

        // I-type layout for SYSTEM: csr[31:20] rs1[19:15] f3[14:12] rd[11:7]
        next_cmd.sys_op = sys_funct3_t'(instr[14:12]);
        next_cmd.csr = csr_addr_t'(instr[31:20]); // Unknown CSRs pass through too
        next_cmd.rd = instr[11:7];
        next_cmd.is_system = (opcode == OP_SYSTEM); // Execute drops the rest
    end

    // Valid bit of the pipeline entry
    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_out.valid <= 1'b0;
        end else if (instr_ready) begin
            cmd_out.valid <= instr_valid; // Refill or drain
        end
    end

    // Held command, stays put while stalled
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_out.cmd <= next_cmd;
        end
    end

endmodule

/* logic/sys_intf.sv */
`timescale 1ns/10ps

`include "sys_settings.svh"

// Decoded command from decode to execute
interface sys_cmd_intf
    import sys_pkg::*;
();
    logic     valid;
    logic     ready;
    sys_cmd_t cmd;

    modport src (output valid, output cmd, input ready);
    modport dst (input valid, input cmd, output ready);
endinterface

// Register writeback result from execute to writeback
interface sys_result_intf ();
    logic                       valid;
    logic                       ready;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [`XLEN-1:0]           value;

    modport src (
        output valid,
        output rd,
        output value,
        input  ready
    );
    modport dst (
        input  valid,
        input  rd,
        input  value,
        output ready
    );
endinterface

/* logic/sys_pkg.sv */
`include "sys_settings.svh"

package sys_pkg;

    // RV32I major opcodes, bits [6:0]
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_FENCE  = 7'b0001111,
        OP_IMM    = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_STORE  = 7'b0100011,
        OP_OP     = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111,
        OP_SYSTEM = 7'b1110011
    } opcode_t;

    // funct3 of SYSTEM instructions
    typedef enum logic [2:0] {
        ENV    = 3'b000, // ECALL / EBREAK
        CSRRW  = 3'b001,
        CSRRS  = 3'b010,
        CSRRC  = 3'b011,
        CSRRWI = 3'b101,
        CSRRSI = 3'b110,
        CSRRCI = 3'b111
    } sys_funct3_t;

    // Read-only user counter CSRs
    typedef enum logic [11:0] {
        CSR_CYCLE    = 12'hC00,
        CSR_TIME     = 12'hC01,
        CSR_INSTRET  = 12'hC02,
        CSR_CYCLEH   = 12'hC80,
        CSR_TIMEH    = 12'hC81,
        CSR_INSTRETH = 12'hC82
    } csr_addr_t;

    typedef struct packed {
        sys_funct3_t                sys_op;
        csr_addr_t                  csr;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic                       is_system; // Opcode was SYSTEM
    } sys_cmd_t;

    typedef struct packed {
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`XLEN-1:0]           value;
    } sys_result_t;

    typedef logic [`RETIRE_WIDTH-1:0] retired_count_t;

endpackage

/* include/sys_settings.svh */
`ifndef SYS_SETTINGS_SVH
`define SYS_SETTINGS_SVH

// Datapath width of the core
`define XLEN 32

// Full width of the cycle and instret counters
`define CNT_WIDTH 64

`define REG_ADDR_WIDTH 5 // x0..x31

// Instructions that can retire in one cycle, as a count
`define RETIRE_WIDTH 2

// 0 makes every counter CSR read back as zero
`define ENABLE_PERF_COUNTERS 1

`endif
